// File: verilog/int_exe_pkg.sv
package int_exe_pkg;

    localparam int XLEN      = 64;  // RV64 register width
    localparam int NUM_AREGS = 32;
    localparam int AREG_W    = 5;
    localparam int ROBID_W   = 6;

    typedef logic [XLEN-1:0]    t_rv_reg_data;
    typedef logic [XLEN-1:0]    t_paddr;
    typedef logic [AREG_W-1:0]  t_areg;
    typedef logic [ROBID_W-1:0] t_robid;

    // micro-ops handled by the integer cluster
    typedef enum logic [4:0] {
        U_BR_EQ,
        U_BR_NE,
        U_BR_LT,
        U_BR_GE,
        U_BR_LTU,
        U_BR_GEU,
        U_JAL,
        U_JALR,
        U_ADD,
        U_SUB,
        U_AND,
        U_OR,
        U_XOR,
        U_SLT,
        U_SLTU,
        U_SLL,
        U_SRL,
        U_SRA
    } t_uop;

    typedef struct packed {
        t_paddr       pc;
        t_uop         uop;
        t_areg        rs1;
        t_areg        rs2;
        t_areg        rd;
        logic         rd_wr;     // op writes rd
        logic         src2_imm;  // alu takes imm64 in place of rs2
        t_rv_reg_data imm64;     // already sign extended
    } t_uinstr;

    typedef struct packed {
        t_uinstr uinstr;
        t_robid  robid;
    } t_iss_pkt;

    // redirect request from a resolved branch
    typedef struct packed {
        logic   valid;
        t_paddr target_addr;
        t_robid robid;
    } t_br_mispred_pkt;

    // completion, also used as register write and forward
    typedef struct packed {
        logic         valid;
        t_robid       robid;
        t_areg        rd;
        logic         rd_wr;
        t_rv_reg_data result;
    } t_comp_pkt;

endpackage

// File: verilog/opnd_read.sv
module opnd_read (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      iss,
    input  int_exe_pkg::t_iss_pkt     iss_pkt,

    input  int_exe_pkg::t_comp_pkt    ex0_fwd,  // op currently in EX0
    input  int_exe_pkg::t_comp_pkt    wb,       // op in writeback, also the array write

    output logic                      iss_ex0,
    output int_exe_pkg::t_iss_pkt     iss_pkt_ex0,
    output int_exe_pkg::t_rv_reg_data src1val_ex0,
    output int_exe_pkg::t_rv_reg_data src2val_ex0
);

    int_exe_pkg::t_rv_reg_data regs [int_exe_pkg::NUM_AREGS];

    int_exe_pkg::t_uinstr      uinstr_rd;
    int_exe_pkg::t_rv_reg_data src1val_rd;
    int_exe_pkg::t_rv_reg_data src2val_rd;

    // reads one source with x0 and the two-level bypass applied
    // the EX0 producer is younger than the one in writeback, so it is checked first
    function automatic int_exe_pkg::t_rv_reg_data bypass_read(
        input int_exe_pkg::t_areg rs
    );
        int_exe_pkg::t_rv_reg_data val;
        if (rs == '0) begin
            val = '0;                                       // x0 is hardwired
        end else if (ex0_fwd.valid && ex0_fwd.rd_wr && (ex0_fwd.rd == rs)) begin
            val = ex0_fwd.result;
        end else if (wb.valid && wb.rd_wr && (wb.rd == rs)) begin
            val = wb.result;                                // array not written yet
        end else begin
            val = regs[rs];
        end
        return val;
    endfunction

    // array write at the end of the writeback cycle
    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd_wr && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.result;
        end
    end

    assign uinstr_rd = iss_pkt.uinstr;

    always_comb begin
        src1val_rd = bypass_read(uinstr_rd.rs1);
        src2val_rd = bypass_read(uinstr_rd.rs2);
    end

    // RD -> EX0 valid
    always_ff @(posedge clk) begin
        if (reset) begin
            iss_ex0 <= 1'b0;
        end else begin
            iss_ex0 <= iss;
        end
    end

    // payload only moves on an issue
    always_ff @(posedge clk) begin
        if (iss) begin
            iss_pkt_ex0 <= iss_pkt;
            src1val_ex0 <= src1val_rd;
            src2val_ex0 <= src2val_rd;
        end
    end

endmodule

// File: verilog/ibr.sv
module ibr (
    input  logic                         iss_ex0,
    input  int_exe_pkg::t_iss_pkt        iss_pkt_ex0,
    input  int_exe_pkg::t_rv_reg_data    src1val_ex0,
    input  int_exe_pkg::t_rv_reg_data    src2val_ex0,

    output logic                         resvld_ex0,
    output int_exe_pkg::t_rv_reg_data    result_ex0,
    output int_exe_pkg::t_br_mispred_pkt br_mispred_ex0
);

    int_exe_pkg::t_uinstr      uinstr_ex0;
    int_exe_pkg::t_paddr       pcnxt_ex0;     // fall-through pc
    int_exe_pkg::t_paddr       tkn_tgt_ex0;
    int_exe_pkg::t_paddr       tru_tgt_ex0;
    int_exe_pkg::t_rv_reg_data jalr_sum_ex0;
    logic                      tkn_ex0;

    assign uinstr_ex0 = iss_pkt_ex0.uinstr;

    assign resvld_ex0 = iss_ex0 && (uinstr_ex0.uop inside {
        int_exe_pkg::U_BR_EQ,  int_exe_pkg::U_BR_NE,
        int_exe_pkg::U_BR_LT,  int_exe_pkg::U_BR_GE,
        int_exe_pkg::U_BR_LTU, int_exe_pkg::U_BR_GEU,
        int_exe_pkg::U_JAL,    int_exe_pkg::U_JALR
    });

    assign pcnxt_ex0  = uinstr_ex0.pc + 64'd4;
    assign result_ex0 = pcnxt_ex0;               // link value

    assign jalr_sum_ex0 = src1val_ex0 + uinstr_ex0.imm64;

    always_comb begin
        if (uinstr_ex0.uop == int_exe_pkg::U_JALR) begin
            tkn_tgt_ex0 = {jalr_sum_ex0[int_exe_pkg::XLEN-1:1], 1'b0};
        end else begin
            tkn_tgt_ex0 = uinstr_ex0.pc + uinstr_ex0.imm64;
        end
    end

    always_comb begin
        case (uinstr_ex0.uop)
            int_exe_pkg::U_BR_EQ:  tkn_ex0 = (src1val_ex0 == src2val_ex0);
            int_exe_pkg::U_BR_NE:  tkn_ex0 = (src1val_ex0 != src2val_ex0);
            int_exe_pkg::U_BR_LT:  tkn_ex0 = ($signed(src1val_ex0) <  $signed(src2val_ex0));
            int_exe_pkg::U_BR_GE:  tkn_ex0 = ($signed(src1val_ex0) >= $signed(src2val_ex0));
            int_exe_pkg::U_BR_LTU: tkn_ex0 = (src1val_ex0 <  src2val_ex0);
            int_exe_pkg::U_BR_GEU: tkn_ex0 = (src1val_ex0 >= src2val_ex0);
            int_exe_pkg::U_JAL,
            int_exe_pkg::U_JALR:   tkn_ex0 = 1'b1;  // jumps always taken
            default:               tkn_ex0 = 1'b0;
        endcase
    end

    assign tru_tgt_ex0 = tkn_ex0 ? tkn_tgt_ex0 : pcnxt_ex0;

    // front end always predicts fall-through
    assign br_mispred_ex0.valid       = resvld_ex0 && (tru_tgt_ex0 != pcnxt_ex0);
    assign br_mispred_ex0.target_addr = tru_tgt_ex0;
    assign br_mispred_ex0.robid       = iss_pkt_ex0.robid;

endmodule

// File: verilog/ialu.sv
module ialu (
    input  logic                      iss_ex0,
    input  int_exe_pkg::t_iss_pkt     iss_pkt_ex0,
    input  int_exe_pkg::t_rv_reg_data src1val_ex0,
    input  int_exe_pkg::t_rv_reg_data src2val_ex0,

    output logic                      resvld_ex0,
    output int_exe_pkg::t_rv_reg_data result_ex0
);

    int_exe_pkg::t_uinstr      uinstr_ex0;
    int_exe_pkg::t_rv_reg_data opa_ex0;
    int_exe_pkg::t_rv_reg_data opb_ex0;
    logic [5:0]                shamt_ex0;

    assign uinstr_ex0 = iss_pkt_ex0.uinstr;

    assign opa_ex0   = src1val_ex0;
    assign opb_ex0   = uinstr_ex0.src2_imm ? uinstr_ex0.imm64 : src2val_ex0;
    assign shamt_ex0 = opb_ex0[5:0];              // RV64 shifts use 6 bits

    assign resvld_ex0 = iss_ex0 && (uinstr_ex0.uop inside {
        int_exe_pkg::U_ADD, int_exe_pkg::U_SUB,
        int_exe_pkg::U_AND, int_exe_pkg::U_OR,
        int_exe_pkg::U_XOR, int_exe_pkg::U_SLT,
        int_exe_pkg::U_SLTU,
        int_exe_pkg::U_SLL, int_exe_pkg::U_SRL,
        int_exe_pkg::U_SRA
    });

    always_comb begin
        case (uinstr_ex0.uop)
            int_exe_pkg::U_ADD:  result_ex0 = opa_ex0 + opb_ex0;
            int_exe_pkg::U_SUB:  result_ex0 = opa_ex0 - opb_ex0;
            int_exe_pkg::U_AND:  result_ex0 = opa_ex0 & opb_ex0;
            int_exe_pkg::U_OR:   result_ex0 = opa_ex0 | opb_ex0;
            int_exe_pkg::U_XOR:  result_ex0 = opa_ex0 ^ opb_ex0;
            int_exe_pkg::U_SLT: begin
                result_ex0 = '0;
                result_ex0[0] = ($signed(opa_ex0) < $signed(opb_ex0));
            end
            int_exe_pkg::U_SLTU: begin
                result_ex0 = '0;
                result_ex0[0] = (opa_ex0 < opb_ex0);
            end
            int_exe_pkg::U_SLL:  result_ex0 = opa_ex0 << shamt_ex0;
            int_exe_pkg::U_SRL:  result_ex0 = opa_ex0 >> shamt_ex0;
            int_exe_pkg::U_SRA: begin
                // arithmetic shift keeps the sign bit
                result_ex0 = int_exe_pkg::t_rv_reg_data'($signed(opa_ex0) >>> shamt_ex0);
            end
            default:             result_ex0 = '0;    // branch ops, result unused
        endcase
    end

endmodule

// File: verilog/exe_wb.sv
module exe_wb (
    input  logic                         clk,
    input  logic                         reset,

    input  int_exe_pkg::t_iss_pkt        iss_pkt_ex0,
    input  logic                         br_resvld_ex0,
    input  logic                         alu_resvld_ex0,
    input  int_exe_pkg::t_rv_reg_data    br_result_ex0,
    input  int_exe_pkg::t_rv_reg_data    alu_result_ex0,
    input  int_exe_pkg::t_br_mispred_pkt br_mispred_ex0,

    output int_exe_pkg::t_comp_pkt       ex0_fwd,
    output int_exe_pkg::t_comp_pkt       comp,
    output int_exe_pkg::t_br_mispred_pkt br_mispred
);

    int_exe_pkg::t_rv_reg_data result_ex0;

    // at most one unit claims the op
    assign result_ex0 = br_resvld_ex0 ? br_result_ex0 : alu_result_ex0;

    always_comb begin
        ex0_fwd.valid  = br_resvld_ex0 | alu_resvld_ex0;
        ex0_fwd.robid  = iss_pkt_ex0.robid;
        ex0_fwd.rd     = iss_pkt_ex0.uinstr.rd;
        ex0_fwd.rd_wr  = iss_pkt_ex0.uinstr.rd_wr;
        ex0_fwd.result = result_ex0;
    end

    // EX0 -> WB, later assignment of the valid bits wins in reset
    always_ff @(posedge clk) begin
        comp       <= ex0_fwd;
        br_mispred <= br_mispred_ex0;
        if (reset) begin
            comp.valid       <= 1'b0;
            br_mispred.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/int_exe_top.sv
module int_exe_top (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         iss,
    input  int_exe_pkg::t_iss_pkt        iss_pkt,

    output int_exe_pkg::t_comp_pkt       comp,
    output int_exe_pkg::t_br_mispred_pkt br_mispred
);

    logic                         iss_ex0;
    int_exe_pkg::t_iss_pkt        iss_pkt_ex0;
    int_exe_pkg::t_rv_reg_data    src1val_ex0;
    int_exe_pkg::t_rv_reg_data    src2val_ex0;

    logic                         br_resvld_ex0;
    int_exe_pkg::t_rv_reg_data    br_result_ex0;
    int_exe_pkg::t_br_mispred_pkt br_mispred_ex0;

    logic                         alu_resvld_ex0;
    int_exe_pkg::t_rv_reg_data    alu_result_ex0;

    int_exe_pkg::t_comp_pkt       ex0_fwd;

    // comp doubles as the register file write port
    opnd_read opnd_read_inst (
        .clk         (clk),
        .reset       (reset),
        .iss         (iss),
        .iss_pkt     (iss_pkt),
        .ex0_fwd     (ex0_fwd),
        .wb          (comp),
        .iss_ex0     (iss_ex0),
        .iss_pkt_ex0 (iss_pkt_ex0),
        .src1val_ex0 (src1val_ex0),
        .src2val_ex0 (src2val_ex0)
    );

    ibr ibr_inst (
        .iss_ex0        (iss_ex0),
        .iss_pkt_ex0    (iss_pkt_ex0),
        .src1val_ex0    (src1val_ex0),
        .src2val_ex0    (src2val_ex0),
        .resvld_ex0     (br_resvld_ex0),
        .result_ex0     (br_result_ex0),
        .br_mispred_ex0 (br_mispred_ex0)
    );

    ialu ialu_inst (
        .iss_ex0     (iss_ex0),
        .iss_pkt_ex0 (iss_pkt_ex0),
        .src1val_ex0 (src1val_ex0),
        .src2val_ex0 (src2val_ex0),
        .resvld_ex0  (alu_resvld_ex0),
        .result_ex0  (alu_result_ex0)
    );

    exe_wb exe_wb_inst (
        .clk            (clk),
        .reset          (reset),
        .iss_pkt_ex0    (iss_pkt_ex0),
        .br_resvld_ex0  (br_resvld_ex0),
        .alu_resvld_ex0 (alu_resvld_ex0),
        .br_result_ex0  (br_result_ex0),
        .alu_result_ex0 (alu_result_ex0),
        .br_mispred_ex0 (br_mispred_ex0),
        .ex0_fwd        (ex0_fwd),
        .comp           (comp),
        .br_mispred     (br_mispred)
    );

endmodule

// File: verif/int_exe_asserts.sv
module int_exe_asserts (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         iss,
    input  int_exe_pkg::t_comp_pkt       comp,
    input  int_exe_pkg::t_br_mispred_pkt br_mispred
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;  // failed properties so far

    // every issued op completes exactly two cycles later
    comp_after_iss: assert property (@(posedge clk) disable iff (reset)
        iss |-> ##2 comp.valid)
        else begin
            fail_cnt++;
            $error("comp.valid missing two cycles after an issue strobe");
        end

    // and nothing completes without an issue two cycles before
    comp_needs_iss: assert property (@(posedge clk) disable iff (reset)
        comp.valid |-> $past(iss, 2))
        else begin
            fail_cnt++;
            $error("comp.valid high without an issue two cycles earlier");
        end

    mispred_with_comp: assert property (@(posedge clk)
        br_mispred.valid |-> comp.valid)
        else begin
            fail_cnt++;
            $error("br_mispred.valid high in a cycle without comp.valid");
        end

    // covers the reset cycles and the first cycle after release
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!comp.valid && !br_mispred.valid))
        else begin
            fail_cnt++;
            $error("comp or br_mispred valid during or right after reset");
        end

endmodule

bind int_exe_top int_exe_asserts int_exe_asserts_inst (
    .clk        (clk),
    .reset      (reset),
    .iss        (iss),
    .comp       (comp),
    .br_mispred (br_mispred)
);

// File: verif/int_exe_tb.sv
module int_exe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int N_ALU_RAND   = 300;
    localparam int N_DIRECTED   = 200;  // upper bound on the directed ops
    localparam int WDOG_CYCLES  = (N_ALU_RAND + N_DIRECTED) * 4 + 50;

    typedef struct packed {
        int_exe_pkg::t_comp_pkt       comp;
        int_exe_pkg::t_br_mispred_pkt mispred;
        logic                         is_br;
    } t_expect;

    logic                         clk;
    logic                         reset;
    logic                         iss;
    int_exe_pkg::t_iss_pkt        iss_pkt;
    int_exe_pkg::t_comp_pkt       comp;
    int_exe_pkg::t_br_mispred_pkt br_mispred;

    int_exe_pkg::t_rv_reg_data shadow [32];  // architectural view in issue order
    int_exe_pkg::t_robid       next_robid;
    logic [31:0]               rng_state;
    string                     cur_test;
    t_expect                   exp_q [$];
    string                     name_q [$];

    int_exe_top int_exe_top_inst (
        .clk        (clk),
        .reset      (reset),
        .iss        (iss),
        .iss_pkt    (iss_pkt),
        .comp       (comp),
        .br_mispred (br_mispred)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function logic [63:0] rand64();
        return {next_rand(), next_rand()};
    endfunction

    function automatic logic is_branch(input int_exe_pkg::t_uop uop);
        return uop inside {int_exe_pkg::U_BR_EQ, int_exe_pkg::U_BR_NE, int_exe_pkg::U_BR_LT,
                           int_exe_pkg::U_BR_GE, int_exe_pkg::U_BR_LTU, int_exe_pkg::U_BR_GEU,
                           int_exe_pkg::U_JAL, int_exe_pkg::U_JALR};
    endfunction

    // signed less-than from the sign bits and an unsigned compare
    function automatic logic less_signed(input logic [63:0] a, input logic [63:0] b);
        return (a[63] != b[63]) ? a[63] : (a < b);
    endfunction

    function automatic logic [63:0] alu_model(input int_exe_pkg::t_uop uop,
                                              input logic [63:0] a, input logic [63:0] b);
        logic [5:0]  sh;
        logic [63:0] fill;
        sh   = b[5:0];
        fill = a[63] ? ~({64{1'b1}} >> sh) : 64'd0;  // sign bits shifted in by SRA
        case (uop)
            int_exe_pkg::U_ADD:  return a + b;
            int_exe_pkg::U_SUB:  return a + ~b + 64'd1;
            int_exe_pkg::U_AND:  return a & b;
            int_exe_pkg::U_OR:   return a | b;
            int_exe_pkg::U_XOR:  return a ^ b;
            int_exe_pkg::U_SLT:  return {63'd0, less_signed(a, b)};
            int_exe_pkg::U_SLTU: return {63'd0, a < b};
            int_exe_pkg::U_SLL:  return a << sh;
            int_exe_pkg::U_SRL:  return a >> sh;
            int_exe_pkg::U_SRA:  return (a >> sh) | fill;
            default:             return 64'd0;
        endcase
    endfunction

    function automatic logic taken_model(input int_exe_pkg::t_uop uop,
                                         input logic [63:0] a, input logic [63:0] b);
        case (uop)
            int_exe_pkg::U_BR_EQ:  return a == b;
            int_exe_pkg::U_BR_NE:  return a != b;
            int_exe_pkg::U_BR_LT:  return less_signed(a, b);
            int_exe_pkg::U_BR_GE:  return !less_signed(a, b);
            int_exe_pkg::U_BR_LTU: return a < b;
            int_exe_pkg::U_BR_GEU: return !(a < b);
            default:               return 1'b1;  // jal and jalr
        endcase
    endfunction

    // computes the expected completion and issues on the next edge
    task automatic send(input int_exe_pkg::t_uop uop, input int_exe_pkg::t_areg rs1,
                        input int_exe_pkg::t_areg rs2, input int_exe_pkg::t_areg rd,
                        input logic rd_wr, input logic src2_imm, input logic [63:0] imm,
                        input int gap);
        int_exe_pkg::t_iss_pkt pkt;
        t_expect               exp;
        logic [63:0]           pc;
        logic [63:0]           tgt;
        pc = rand64() & ~64'd3;
        pkt.uinstr = '{pc: pc, uop: uop, rs1: rs1, rs2: rs2, rd: rd, rd_wr: rd_wr,
                       src2_imm: src2_imm, imm64: imm};
        pkt.robid  = next_robid;
        exp        = '0;
        exp.is_br  = is_branch(uop);
        if (exp.is_br) begin
            tgt = (uop == int_exe_pkg::U_JALR) ? ((shadow[rs1] + imm) & ~64'd1) : pc + imm;
            if (!taken_model(uop, shadow[rs1], shadow[rs2])) tgt = pc + 64'd4;
            exp.comp.result          = pc + 64'd4;  // link
            exp.mispred.valid        = (tgt != pc + 64'd4);
            exp.mispred.target_addr  = tgt;
        end else begin
            exp.comp.result = alu_model(uop, shadow[rs1], src2_imm ? imm : shadow[rs2]);
        end
        exp.comp.valid    = 1'b1;
        exp.comp.robid    = next_robid;
        exp.comp.rd       = rd;
        exp.comp.rd_wr    = rd_wr;
        exp.mispred.robid = next_robid;
        if (rd_wr && rd != 0) shadow[rd] = exp.comp.result;
        exp_q.push_back(exp);
        name_q.push_back(cur_test);
        next_robid++;
        @(posedge clk);
        iss     <= 1'b1;
        iss_pkt <= pkt;
        repeat (gap) begin
            @(posedge clk);
            iss <= 1'b0;
        end
    endtask

    task automatic check_field(input string tn, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
            else abort_run($sformatf("ERROR %s %s expected %h actual %h", tn, field, exp, act));
    endtask

    task automatic check_completion();
        t_expect exp;
        string   tn;
        if (exp_q.size() == 0) begin
            abort_run("a completion came out while no micro-op was outstanding");
        end else begin
            exp = exp_q.pop_front();
            tn  = name_q.pop_front();
            check_field(tn, "comp.robid", exp.comp.robid, comp.robid);
            check_field(tn, "comp.rd", exp.comp.rd, comp.rd);
            check_field(tn, "comp.rd_wr", exp.comp.rd_wr, comp.rd_wr);
            check_field(tn, "comp.result", exp.comp.result, comp.result);
            check_field(tn, "br_mispred.valid", exp.mispred.valid, br_mispred.valid);
            if (exp.is_br) check_field(tn, "br_mispred.robid", exp.mispred.robid, br_mispred.robid);
            if (exp.mispred.valid) begin
                check_field(tn, "br_mispred.target_addr", exp.mispred.target_addr,
                            br_mispred.target_addr);
            end
        end
    endtask

    // outputs settle after the rising edge so sample in the middle of the cycle
    always @(negedge clk) begin
        if (int_exe_top_inst.int_exe_asserts_inst.fail_cnt != 0) begin
            abort_run("a bound timing assertion on int_exe_top failed");
        end
        if (!reset && comp.valid) check_completion();
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles, test did not finish", WDOG_CYCLES));
    end

    initial begin
        int_exe_pkg::t_uop alu_uops [10];
        logic [63:0]       pair_a [8];
        logic [63:0]       pair_b [8];
        logic [63:0]       br_imms [4];
        logic [31:0]       r;
        alu_uops = '{int_exe_pkg::U_ADD, int_exe_pkg::U_SUB, int_exe_pkg::U_AND, int_exe_pkg::U_OR,
                     int_exe_pkg::U_XOR, int_exe_pkg::U_SLT, int_exe_pkg::U_SLTU,
                     int_exe_pkg::U_SLL, int_exe_pkg::U_SRL, int_exe_pkg::U_SRA};
        pair_a  = '{64'd5, 64'd3, 64'd9, {64{1'b1}}, 64'd1, 64'h8000_0000_0000_0000,
                    64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
        pair_b  = '{64'd5, 64'd9, 64'd3, 64'd1, {64{1'b1}}, 64'h7fff_ffff_ffff_ffff,
                    64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000};
        br_imms = '{64'hffff_ffff_ffff_fff0, 64'd8, 64'd4, 64'd2048};
        rng_state  = 32'h4a9f513c;
        next_robid = '0;
        reset      = 1'b1;
        iss        = 1'b0;
        iss_pkt    = '0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        cur_test = "reg_init";  // give every register a known value before the random ops
        for (int i = 1; i < 32; i++) send(int_exe_pkg::U_ADD, 0, 0, i, 1, 1, rand64(), 0);

        cur_test = "alu_random";
        for (int n = 0; n < N_ALU_RAND; n++) begin
            r = next_rand();
            send(alu_uops[next_rand() % 10], r[4:0], r[9:5], r[14:10], 1, r[15],
                 {{52{r[27]}}, r[27:16]}, next_rand() % 3);
        end

        cur_test = "branch_cond";
        for (int p = 0; p < 8; p++) begin
            send(int_exe_pkg::U_ADD, 0, 0, 10, 1, 1, pair_a[p], 0);
            send(int_exe_pkg::U_ADD, 0, 0, 11, 1, 1, pair_b[p], 0);
            for (int k = 0; k < 6; k++) begin
                send(int_exe_pkg::t_uop'(k), 10, 11, 0, 0, 0, br_imms[(p + k) % 4], k % 2);
            end
        end

        cur_test = "jump";
        send(int_exe_pkg::U_JAL, 0, 0, 5, 1, 0, 64'h100, 0);
        send(int_exe_pkg::U_ADD, 5, 0, 6, 1, 1, 64'd0, 0);   // link read through EX0 bypass
        send(int_exe_pkg::U_JAL, 0, 0, 5, 1, 0, 64'd4, 1);   // lands on pc+4 so no redirect
        send(int_exe_pkg::U_ADD, 0, 0, 10, 1, 1, 64'h1235, 0);
        send(int_exe_pkg::U_JALR, 10, 0, 7, 1, 0, 64'h10, 0);  // odd sum gets bit 0 cleared
        send(int_exe_pkg::U_JALR, 10, 0, 7, 1, 0, 64'hffff_ffff_ffff_ff00, 2);
        send(int_exe_pkg::U_ADD, 7, 0, 8, 1, 0, 64'd0, 0);

        cur_test = "bypass";
        for (int g = 0; g < 3; g++) begin
            send(int_exe_pkg::U_ADD, 0, 0, 12, 1, 1, 64'd5 + g, g);
            send(int_exe_pkg::U_ADD, 12, 0, 13, 1, 1, 64'd3, g);
            send(int_exe_pkg::U_XOR, 13, 12, 12, 1, 0, 64'd0, g);
            send(int_exe_pkg::U_SUB, 12, 13, 12, 1, 0, 64'd0, g);  // x12 again, youngest wins
            send(int_exe_pkg::U_SLL, 12, 13, 14, 1, 0, 64'd0, g);
            send(int_exe_pkg::U_ADD, 14, 12, 15, 1, 0, 64'd0, g);
        end

        cur_test = "x0_reads";
        for (int g = 0; g < 3; g++) begin
            send(int_exe_pkg::U_ADD, 0, 0, 0, 1, 1, 64'h777, g);  // write to x0 is dropped
            send(int_exe_pkg::U_OR, 0, 0, 16 + g, 1, 0, 64'd0, g);
        end

        @(posedge clk);
        iss <= 1'b0;
        repeat (4) @(posedge clk);  // the last op completes two cycles after its issue
        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("expected completions are still outstanding at the end");
        end
    end

endmodule

// File: flist.f
verilog/int_exe_pkg.sv
verilog/opnd_read.sv
verilog/ibr.sv
verilog/ialu.sv
verilog/exe_wb.sv
verilog/int_exe_top.sv
verif/int_exe_asserts.sv
verif/int_exe_tb.sv
